/* verification/issue_stim.txt */
// columns in hex: wid rd rs1 rs2 wb unit a b expected
// unit 0 is the adder and 1 the multiplier, expected is ignored when wb is 0
0 01 00 00 1 1 00000003 00000005 0000000f
1 01 00 00 1 0 00000010 00000020 00000030
0 02 01 00 1 0 0000000f 00000001 00000010
0 03 00 00 1 1 00001000 00001000 01000000
0 03 00 00 1 0 00000007 00000008 0000000f
2 05 00 00 0 0 12345678 11111111 23456789
2 06 00 00 1 1 ffffffff 00000002 fffffffe
3 07 06 06 1 0 80000000 80000000 00000000
2 08 06 00 1 0 00000001 00000002 00000003
1 09 00 00 1 1 00010000 00010000 00000000
1 0a 09 01 1 1 00000002 00000003 00000006
0 03 03 00 1 1 00000004 00000004 00000010
3 0b 00 00 0 1 00000005 00000005 00000019
2 06 00 00 1 0 00000100 00000200 00000300
0 0c 00 00 1 0 deadbeef 00000001 deadbef0
3 0c 00 00 1 0 0000000a 0000000b 00000015
1 0c 0a 00 1 1 00000007 00000006 0000002a
0 0d 0c 0c 1 1 00000003 00000003 00000009

/* compile.f */
+incdir+include
src/issue_pkg.sv
src/scoreboard.sv
src/exec_unit.sv
src/writeback_arbiter.sv
src/issue_top.sv
verification/scoreboard_props.sv
verification/issue_tb.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module issue_tb -f compile.f -o issue_sim \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/issue_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "STATUS: PASS" && echo "run succeeded" \
    || { echo "run did not succeed"; exit 1; }

/* verification/issue_tb.sv */
// ------------------------------
// reads at most 64 stim lines
// results come from the stim file
// writebacks are paired by warp
// and register in issue order
// ------------------------------
`default_nettype none

`include "issue_config.svh"

module issue_tb;
    import issue_pkg::*;

    localparam int  MAX_LINES  = 64;
    localparam int  CLK_PERIOD = 20;
    // staging, one adder stage and at most one lost arbitration
    localparam time ADD_BOUND  = 4 * CLK_PERIOD;

    logic      clk;
    logic      reset;
    logic      in_valid;
    logic      in_ready;
    warp_id_t  in_wid;
    reg_id_t   in_rd;
    reg_id_t   in_rs1;
    reg_id_t   in_rs2;
    logic      in_wb;
    unit_sel_t in_unit;
    data_t     in_a;
    data_t     in_b;
    logic      wb_valid;
    warp_id_t  wb_wid;
    reg_id_t   wb_rd;
    data_t     wb_data;

    warp_id_t  s_wid  [MAX_LINES];
    reg_id_t   s_rd   [MAX_LINES];
    reg_id_t   s_rs1  [MAX_LINES];
    reg_id_t   s_rs2  [MAX_LINES];
    logic      s_wb   [MAX_LINES];
    unit_sel_t s_unit [MAX_LINES];
    data_t     s_a    [MAX_LINES];
    data_t     s_b    [MAX_LINES];
    data_t     s_exp  [MAX_LINES];

    bit    issued   [MAX_LINES];
    bit    seen     [MAX_LINES];
    time   acc_t    [MAX_LINES];
    time   wb_t     [MAX_LINES];
    data_t got_data [MAX_LINES];
    data_t last_val [`ISSUE_NUM_WARPS][`ISSUE_NUM_REGS];

    int     n_lines;
    int     wb_lines;
    int     wb_count;
    int     stray_count;
    int     errors;
    int     pass_count;
    int     fail_count;
    int     match_idx;
    integer seed;

    issue_top issue_top_inst (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_wid   (in_wid),
        .in_rd    (in_rd),
        .in_rs1   (in_rs1),
        .in_rs2   (in_rs2),
        .in_wb    (in_wb),
        .in_unit  (in_unit),
        .in_a     (in_a),
        .in_b     (in_b),
        .wb_valid (wb_valid),
        .wb_wid   (wb_wid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] time %0t: %s, got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: passed", name);
            pass_count++;
        end else begin
            $display("test %s: failed with %0d errors", name, errors - errors_before);
            fail_count++;
        end
    endtask

    task automatic send_instr(input int k);
        int gap;
        gap = int'($unsigned($random(seed)) % 3);
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        in_wid    = s_wid[k];
        in_rd     = s_rd[k];
        in_rs1    = s_rs1[k];
        in_rs2    = s_rs2[k];
        in_wb     = s_wb[k];
        in_unit   = s_unit[k];
        in_a      = s_a[k];
        in_b      = s_b[k];
        in_valid  = 1'b1;
        issued[k] = 1'b1;
        // in_ready follows the slot state, which only moves on a clock edge
        while (!in_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        acc_t[k] = $time;
        #1;
        in_valid = 1'b0;
    endtask

    // each strobe belongs to the oldest pending line of the same warp and register
    always @(negedge clk) begin
        if (!reset && wb_valid) begin
            match_idx = -1;
            for (int k = 0; k < n_lines; k++) begin
                if (match_idx < 0 && issued[k] && s_wb[k] && !seen[k]
                    && s_wid[k] == wb_wid && s_rd[k] == wb_rd) begin
                    match_idx = k;
                end
            end
            if (match_idx < 0) begin
                $display("unexpected writeback at time %0t to warp %0d register %0d",
                         $time, wb_wid, wb_rd);
                stray_count++;
            end else begin
                seen[match_idx]         = 1'b1;
                wb_t[match_idx]         = $time;
                got_data[match_idx]     = wb_data;
                last_val[wb_wid][wb_rd] = wb_data;
                wb_count++;
            end
        end
    end

    initial begin
        int    fd;
        int    r;
        int    e0;
        int    pairs;
        bit    last;
        bit    blocked;
        string line;
        seed     = 42;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_wid   = '0;
        in_rd    = '0;
        in_rs1   = '0;
        in_rs2   = '0;
        in_wb    = 1'b0;
        in_unit  = 1'b0;
        in_a     = '0;
        in_b     = '0;
        fd = $fopen("verification/issue_stim.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                r = $fgets(line, fd);
                if (r > 0) begin
                    r = $sscanf(line, "%h %h %h %h %h %h %h %h %h", s_wid[n_lines],
                                s_rd[n_lines], s_rs1[n_lines], s_rs2[n_lines], s_wb[n_lines],
                                s_unit[n_lines], s_a[n_lines], s_b[n_lines], s_exp[n_lines]);
                    if (r == 9) begin
                        if (s_wb[n_lines]) begin
                            wb_lines++;
                        end
                        n_lines++;
                    end
                end
            end
            $fclose(fd);
        end
        if (n_lines == 0) begin
            $display("no instructions could be read from verification/issue_stim.txt");
            $display("STATUS: FAIL");
            $finish;
        end else begin
            e0 = errors;
            repeat (3) begin
                @(posedge clk);
                #1;
                check_value(data_t'(wb_valid), 32'd0, "wb_valid during reset");
                check_value(data_t'(in_ready), 32'd1, "in_ready during reset");
            end
            reset = 1'b0;
            @(posedge clk);
            #1;
            check_value(data_t'(wb_valid), 32'd0, "wb_valid after reset");
            check_value(data_t'(in_ready), 32'd1, "in_ready after reset");
            report_test("reset", e0);

            for (int k = 0; k < n_lines; k++) begin
                send_instr(k);
            end
            wait (wb_count == wb_lines);
            // a quiet stretch so that a late extra strobe is still caught
            repeat (10) @(posedge clk);

            e0 = errors;
            for (int k = 0; k < n_lines; k++) begin
                if (s_wb[k]) begin
                    check_value(data_t'(seen[k]), 32'd1, $sformatf("line %0d writeback", k));
                    check_value(got_data[k], s_exp[k], $sformatf("line %0d result", k));
                end
            end
            check_value(data_t'(stray_count), 32'd0, "writebacks with no pending line");
            report_test("results", e0);

            e0 = errors;
            pairs = 0;
            for (int j = 0; j < n_lines; j++) begin
                for (int i = 0; i < j; i++) begin
                    if (s_wb[i] && s_wb[j] && s_unit[i] == 1'b1 && s_wid[i] == s_wid[j]
                        && (s_rd[i] == s_rs1[j] || s_rd[i] == s_rs2[j])) begin
                        pairs++;
                        check_value(data_t'(wb_t[i] < wb_t[j]), 32'd1,
                                    $sformatf("line %0d before reader line %0d", i, j));
                    end
                end
            end
            check_value(data_t'(pairs > 0), 32'd1, "read-after-write pairs in the stim");
            report_test("read after write", e0);

            e0 = errors;
            for (int j = 0; j < n_lines; j++) begin
                if (s_wb[j]) begin
                    last = 1'b1;
                    for (int i = 0; i < n_lines; i++) begin
                        if (i != j && s_wb[i] && s_wid[i] == s_wid[j] && s_rd[i] == s_rd[j]) begin
                            if (i > j) begin
                                last = 1'b0;
                            end else begin
                                check_value(data_t'(wb_t[i] < wb_t[j]), 32'd1,
                                            $sformatf("line %0d before line %0d", i, j));
                            end
                        end
                    end
                    if (last) begin
                        check_value(last_val[s_wid[j]][s_rd[j]], s_exp[j],
                                    $sformatf("final value of line %0d", j));
                    end
                end
            end
            report_test("write after write", e0);

            e0 = errors;
            // every strobe counts, also those that matched no pending line
            check_value(data_t'(wb_count + stray_count), data_t'(wb_lines), "writeback count");
            for (int j = 0; j < n_lines; j++) begin
                if (s_wb[j] && s_unit[j] == 1'b0) begin
                    blocked = 1'b0;
                    for (int i = 0; i < j; i++) begin
                        if (s_wb[i] && s_wid[i] == s_wid[j] && wb_t[i] > acc_t[j]
                            && (s_rd[i] == s_rd[j] || s_rd[i] == s_rs1[j]
                                || s_rd[i] == s_rs2[j])) begin
                            blocked = 1'b1;
                        end
                    end
                    // other warps must not hold back an adder line
                    if (!blocked) begin
                        check_value(data_t'(wb_t[j] - acc_t[j] <= ADD_BOUND), 32'd1,
                                    $sformatf("line %0d adder latency", j));
                    end
                end
            end
            report_test("warp isolation and count", e0);

            $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
            $finish;
        end
    end

    // 40 cycles per instruction plus some slack for reset
    initial begin
        wait (n_lines > 0);
        #(n_lines * 40 * CLK_PERIOD + 10 * CLK_PERIOD);
        $display("timeout: the writebacks did not all arrive in time");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/scoreboard_props.sv */
// ------------------------------
// bound to every scoreboard
// checked only outside reset
// ------------------------------
`default_nettype none

`include "issue_config.svh"

module scoreboard_props (
    input logic                                             clk,
    input logic                                             reset,
    input logic                                             in_valid,
    input logic                                             in_ready,
    input logic                                             alu_valid,
    input logic                                             alu_ready,
    input logic                                             mul_valid,
    input logic                                             mul_ready,
    input logic                                             wb_valid,
    input issue_pkg::warp_id_t                              stg_wid,
    input issue_pkg::warp_id_t                              wb_wid,
    input issue_pkg::reg_id_t                               stg_rd,
    input issue_pkg::reg_id_t                               stg_rs1,
    input issue_pkg::reg_id_t                               stg_rs2,
    input issue_pkg::reg_id_t                               wb_rd,
    input logic [`ISSUE_NUM_WARPS-1:0][`ISSUE_NUM_REGS-1:0] inuse_regs
);
    import issue_pkg::*;

    logic rd_busy;
    logic rs1_busy;
    logic rs2_busy;
    logic slot_full;

    // a register stays busy unless this cycle's writeback frees it
    assign rd_busy  = inuse_regs[stg_wid][stg_rd]
                   && !(wb_valid && wb_wid == stg_wid && wb_rd == stg_rd);
    assign rs1_busy = inuse_regs[stg_wid][stg_rs1]
                   && !(wb_valid && wb_wid == stg_wid && wb_rd == stg_rs1);
    assign rs2_busy = inuse_regs[stg_wid][stg_rs2]
                   && !(wb_valid && wb_wid == stg_wid && wb_rd == stg_rs2);

    // slot occupancy rebuilt from the input and dispatch handshakes alone
    always_ff @(posedge clk) begin
        if (reset) begin
            slot_full <= 1'b0;
        end else if (in_valid && in_ready) begin
            slot_full <= 1'b1;
        end else if ((alu_valid && alu_ready) || (mul_valid && mul_ready)) begin
            slot_full <= 1'b0;
        end
    end

    wb_hits_inuse: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> inuse_regs[wb_wid][wb_rd])
        else $error("writeback to a register that is not in use");

    full_blocks_input: assert property (@(posedge clk) disable iff (reset)
        slot_full |-> !in_ready)
        else $error("in_ready is high while the staging slot is full");

    no_dispatch_on_hazard: assert property (@(posedge clk) disable iff (reset)
        (alu_valid || mul_valid) |-> !(rd_busy || rs1_busy || rs2_busy))
        else $error("dispatch while a register of the instruction is in use");

endmodule

bind scoreboard scoreboard_props scoreboard_props_inst (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .alu_valid  (alu_valid),
    .alu_ready  (alu_ready),
    .mul_valid  (mul_valid),
    .mul_ready  (mul_ready),
    .wb_valid   (wb_valid),
    .stg_wid    (stg_wid),
    .wb_wid     (wb_wid),
    .stg_rd     (stg_rd),
    .stg_rs1    (stg_rs1),
    .stg_rs2    (stg_rs2),
    .wb_rd      (wb_rd),
    .inuse_regs (inuse_regs)
);

`default_nettype wire

/* src/issue_top.sv */
// ------------------------------
// operands arrive already read
// writeback order across units
// is not issue order
// ------------------------------
`default_nettype none

`include "issue_config.svh"

module issue_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  issue_pkg::warp_id_t  in_wid,
    input  issue_pkg::reg_id_t   in_rd,
    input  issue_pkg::reg_id_t   in_rs1,
    input  issue_pkg::reg_id_t   in_rs2,
    input  logic                 in_wb,
    input  issue_pkg::unit_sel_t in_unit,
    input  issue_pkg::data_t     in_a,
    input  issue_pkg::data_t     in_b,
    output logic                 wb_valid,
    output issue_pkg::warp_id_t  wb_wid,
    output issue_pkg::reg_id_t   wb_rd,
    output issue_pkg::data_t     wb_data
);
    import issue_pkg::*;

    logic     alu_valid;
    logic     alu_ready;
    logic     mul_valid;
    logic     mul_ready;
    warp_id_t disp_wid;
    reg_id_t  disp_rd;
    logic     disp_wb;
    data_t    disp_a;
    data_t    disp_b;

    logic     alu_res_valid;
    logic     alu_res_ready;
    warp_id_t alu_res_wid;
    reg_id_t  alu_res_rd;
    logic     alu_res_wb;
    data_t    alu_res_data;

    logic     mul_res_valid;
    logic     mul_res_ready;
    warp_id_t mul_res_wid;
    reg_id_t  mul_res_rd;
    logic     mul_res_wb;
    data_t    mul_res_data;

    scoreboard scoreboard_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_wid    (in_wid),
        .in_rd     (in_rd),
        .in_rs1    (in_rs1),
        .in_rs2    (in_rs2),
        .in_wb     (in_wb),
        .in_unit   (in_unit),
        .in_a      (in_a),
        .in_b      (in_b),
        .alu_valid (alu_valid),
        .alu_ready (alu_ready),
        .mul_valid (mul_valid),
        .mul_ready (mul_ready),
        .disp_wid  (disp_wid),
        .disp_rd   (disp_rd),
        .disp_wb   (disp_wb),
        .disp_a    (disp_a),
        .disp_b    (disp_b),
        .wb_valid  (wb_valid),
        .wb_wid    (wb_wid),
        .wb_rd     (wb_rd)
    );

    exec_unit #(
        .LATENCY (`ISSUE_ALU_LATENCY),
        .IS_MUL  (1'b0)
    ) alu_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (alu_valid),
        .in_ready  (alu_ready),
        .in_wid    (disp_wid),
        .in_rd     (disp_rd),
        .in_wb     (disp_wb),
        .in_a      (disp_a),
        .in_b      (disp_b),
        .res_valid (alu_res_valid),
        .res_ready (alu_res_ready),
        .res_wid   (alu_res_wid),
        .res_rd    (alu_res_rd),
        .res_wb    (alu_res_wb),
        .res_data  (alu_res_data)
    );

    exec_unit #(
        .LATENCY (`ISSUE_MUL_LATENCY),
        .IS_MUL  (1'b1)
    ) mul_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (mul_valid),
        .in_ready  (mul_ready),
        .in_wid    (disp_wid),
        .in_rd     (disp_rd),
        .in_wb     (disp_wb),
        .in_a      (disp_a),
        .in_b      (disp_b),
        .res_valid (mul_res_valid),
        .res_ready (mul_res_ready),
        .res_wid   (mul_res_wid),
        .res_rd    (mul_res_rd),
        .res_wb    (mul_res_wb),
        .res_data  (mul_res_data)
    );

    writeback_arbiter writeback_arbiter_inst (
        .clk           (clk),
        .reset         (reset),
        .alu_res_valid (alu_res_valid),
        .alu_res_ready (alu_res_ready),
        .alu_res_wid   (alu_res_wid),
        .alu_res_rd    (alu_res_rd),
        .alu_res_wb    (alu_res_wb),
        .alu_res_data  (alu_res_data),
        .mul_res_valid (mul_res_valid),
        .mul_res_ready (mul_res_ready),
        .mul_res_wid   (mul_res_wid),
        .mul_res_rd    (mul_res_rd),
        .mul_res_wb    (mul_res_wb),
        .mul_res_data  (mul_res_data),
        .wb_valid      (wb_valid),
        .wb_wid        (wb_wid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

endmodule

`default_nettype wire

/* src/writeback_arbiter.sv */
// ------------------------------
// two requesters, adder first
// after reset
// results with wb clear are
// consumed without a strobe
// ------------------------------
`default_nettype none

module writeback_arbiter (
    input  logic                clk,
    input  logic                reset,
    input  logic                alu_res_valid,
    output logic                alu_res_ready,
    input  issue_pkg::warp_id_t alu_res_wid,
    input  issue_pkg::reg_id_t  alu_res_rd,
    input  logic                alu_res_wb,
    input  issue_pkg::data_t    alu_res_data,
    input  logic                mul_res_valid,
    output logic                mul_res_ready,
    input  issue_pkg::warp_id_t mul_res_wid,
    input  issue_pkg::reg_id_t  mul_res_rd,
    input  logic                mul_res_wb,
    input  issue_pkg::data_t    mul_res_data,
    output logic                wb_valid,
    output issue_pkg::warp_id_t wb_wid,
    output issue_pkg::reg_id_t  wb_rd,
    output issue_pkg::data_t    wb_data
);
    // high when the multiplier wins a tie
    logic prio_mul;

    assign alu_res_ready = alu_res_valid && (!mul_res_valid || !prio_mul);
    assign mul_res_ready = mul_res_valid && (!alu_res_valid || prio_mul);

    always_ff @(posedge clk) begin
        if (reset) begin
            prio_mul <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            // the unit just served drops to lowest priority
            if (alu_res_ready) begin
                prio_mul <= 1'b1;
            end else if (mul_res_ready) begin
                prio_mul <= 1'b0;
            end
            wb_valid <= (alu_res_ready && alu_res_wb) || (mul_res_ready && mul_res_wb);
        end
    end

    always_ff @(posedge clk) begin
        if (mul_res_ready) begin
            wb_wid  <= mul_res_wid;
            wb_rd   <= mul_res_rd;
            wb_data <= mul_res_data;
        end else begin
            wb_wid  <= alu_res_wid;
            wb_rd   <= alu_res_rd;
            wb_data <= alu_res_data;
        end
    end

endmodule

`default_nettype wire

/* src/exec_unit.sv */
// ------------------------------
// LATENCY must be at least 1
// the whole pipe stalls when the
// last stage is not taken
// ------------------------------
`default_nettype none

module exec_unit #(
    parameter int LATENCY = 1,
    parameter bit IS_MUL  = 1'b0
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    output logic                in_ready,
    input  issue_pkg::warp_id_t in_wid,
    input  issue_pkg::reg_id_t  in_rd,
    input  logic                in_wb,
    input  issue_pkg::data_t    in_a,
    input  issue_pkg::data_t    in_b,
    output logic                res_valid,
    input  logic                res_ready,
    output issue_pkg::warp_id_t res_wid,
    output issue_pkg::reg_id_t  res_rd,
    output logic                res_wb,
    output issue_pkg::data_t    res_data
);
    import issue_pkg::*;

    logic [LATENCY-1:0] stg_valid;
    logic [LATENCY-1:0] stg_wb;
    warp_id_t           stg_wid  [LATENCY];
    reg_id_t            stg_rd   [LATENCY];
    data_t              stg_data [LATENCY];

    data_t op_result;
    logic  advance;

    // the multiplier keeps only the low word of the product
    assign op_result = IS_MUL ? data_t'(in_a * in_b) : data_t'(in_a + in_b);

    assign advance  = !stg_valid[LATENCY-1] || res_ready;
    assign in_ready = advance;

    always_ff @(posedge clk) begin
        if (reset) begin
            stg_valid <= '0;
        end else if (advance) begin
            stg_valid[0] <= in_valid;
            for (int i = 1; i < LATENCY; i++) begin
                stg_valid[i] <= stg_valid[i-1];
            end
        end
    end

    // result is computed on entry, later stages only delay it
    always_ff @(posedge clk) begin
        if (advance) begin
            stg_wid[0]  <= in_wid;
            stg_rd[0]   <= in_rd;
            stg_wb[0]   <= in_wb;
            stg_data[0] <= op_result;
            for (int i = 1; i < LATENCY; i++) begin
                stg_wid[i]  <= stg_wid[i-1];
                stg_rd[i]   <= stg_rd[i-1];
                stg_wb[i]   <= stg_wb[i-1];
                stg_data[i] <= stg_data[i-1];
            end
        end
    end

    assign res_valid = stg_valid[LATENCY-1];
    assign res_wid   = stg_wid[LATENCY-1];
    assign res_rd    = stg_rd[LATENCY-1];
    assign res_wb    = stg_wb[LATENCY-1];
    assign res_data  = stg_data[LATENCY-1];

endmodule

`default_nettype wire

/* src/scoreboard.sv */
// ------------------------------
// one staging slot for all warps
// rd, rs1 and rs2 are all checked
// writeback has no backpressure
// ------------------------------
`default_nettype none

`include "issue_config.svh"

module scoreboard (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  issue_pkg::warp_id_t  in_wid,
    input  issue_pkg::reg_id_t   in_rd,
    input  issue_pkg::reg_id_t   in_rs1,
    input  issue_pkg::reg_id_t   in_rs2,
    input  logic                 in_wb,
    input  issue_pkg::unit_sel_t in_unit,
    input  issue_pkg::data_t     in_a,
    input  issue_pkg::data_t     in_b,
    output logic                 alu_valid,
    input  logic                 alu_ready,
    output logic                 mul_valid,
    input  logic                 mul_ready,
    output issue_pkg::warp_id_t  disp_wid,
    output issue_pkg::reg_id_t   disp_rd,
    output logic                 disp_wb,
    output issue_pkg::data_t     disp_a,
    output issue_pkg::data_t     disp_b,
    input  logic                 wb_valid,
    input  issue_pkg::warp_id_t  wb_wid,
    input  issue_pkg::reg_id_t   wb_rd
);
    import issue_pkg::*;

    staging_state_t state;

    warp_id_t  stg_wid;
    reg_id_t   stg_rd;
    reg_id_t   stg_rs1;
    reg_id_t   stg_rs2;
    logic      stg_wb;
    unit_sel_t stg_unit;
    data_t     stg_a;
    data_t     stg_b;

    logic [`ISSUE_NUM_WARPS-1:0][`ISSUE_NUM_REGS-1:0] inuse_regs;
    logic [`ISSUE_NUM_WARPS-1:0][`ISSUE_NUM_REGS-1:0] inuse_cleared;
    logic [`ISSUE_NUM_WARPS-1:0][`ISSUE_NUM_REGS-1:0] inuse_next;

    logic hazard;
    logic disp_ok;
    logic disp_fire;

    // apply this cycle's writeback first so a waiting instruction can leave now
    always_comb begin
        inuse_cleared = inuse_regs;
        if (wb_valid) begin
            inuse_cleared[wb_wid][wb_rd] = 1'b0;
        end
    end

    assign hazard = inuse_cleared[stg_wid][stg_rd]
                 || inuse_cleared[stg_wid][stg_rs1]
                 || inuse_cleared[stg_wid][stg_rs2];

    assign disp_ok   = (state == stg_full) && !hazard;
    assign alu_valid = disp_ok && (stg_unit == 1'b0);
    assign mul_valid = disp_ok && (stg_unit == 1'b1);
    assign disp_fire = (alu_valid && alu_ready) || (mul_valid && mul_ready);

    // a dispatched writer claims its destination until the result comes back
    always_comb begin
        inuse_next = inuse_cleared;
        if (disp_fire && stg_wb) begin
            inuse_next[stg_wid][stg_rd] = 1'b1;
        end
    end

    assign in_ready = (state == stg_empty);

    always_ff @(posedge clk) begin
        if (reset) begin
            inuse_regs <= '0;
            state      <= stg_empty;
        end else begin
            inuse_regs <= inuse_next;
            case (state)
                stg_empty: begin
                    if (in_valid) begin
                        state <= stg_full;
                    end
                end
                stg_full: begin
                    if (disp_fire) begin
                        state <= stg_empty;
                    end
                end
                default: state <= stg_empty;
            endcase
        end
    end

    // the slot only loads while empty, so it never loads and dispatches together
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            stg_wid  <= in_wid;
            stg_rd   <= in_rd;
            stg_rs1  <= in_rs1;
            stg_rs2  <= in_rs2;
            stg_wb   <= in_wb;
            stg_unit <= in_unit;
            stg_a    <= in_a;
            stg_b    <= in_b;
        end
    end

    assign disp_wid = stg_wid;
    assign disp_rd  = stg_rd;
    assign disp_wb  = stg_wb;
    assign disp_a   = stg_a;
    assign disp_b   = stg_b;

endmodule

`default_nettype wire

/* src/issue_pkg.sv */
// ------------------------------
// shared types of the issue stage
// widths follow issue_config.svh
// ------------------------------
`default_nettype none

`include "issue_config.svh"

package issue_pkg;

    // warp index
    typedef logic [$clog2(`ISSUE_NUM_WARPS)-1:0] warp_id_t;

    // architectural register index
    typedef logic [$clog2(`ISSUE_NUM_REGS)-1:0] reg_id_t;

    // operand or result value
    typedef logic [`ISSUE_DATA_WIDTH-1:0] data_t;

    // target unit, 0 selects the adder and 1 the multiplier
    typedef logic unit_sel_t;

    // occupancy of the one-entry staging slot
    typedef enum logic {
        stg_empty,
        stg_full
    } staging_state_t;

endpackage

`default_nettype wire

/* include/issue_config.svh */
// ------------------------------
// sizing for the issue stage
// latencies must be 1 or more
// warp and register counts must
// be powers of two
// ------------------------------
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// number of warps tracked by the scoreboard
`define ISSUE_NUM_WARPS 4

// architectural registers per warp
`define ISSUE_NUM_REGS 32

// operand and result width
`define ISSUE_DATA_WIDTH 32

// pipeline depths of the two execution units
`define ISSUE_ALU_LATENCY 1
`define ISSUE_MUL_LATENCY 3

`endif
